// File: bender.yml
package:
  name: exu

export_include_dirs:
  - include

sources:
  - logic/exu_pkg.sv
  - logic/exu_regfile_if.sv
  - logic/exu_regfile.sv
  - logic/exu_decode.sv
  - logic/exu_alu.sv
  - logic/exu_execute.sv
  - logic/exu_hazard_ctrl.sv
  - logic/exu_top.sv
  - target: test
    files:
      - test/exu_tb.sv

// File: filelist.f
+incdir+include
logic/exu_pkg.sv
logic/exu_regfile_if.sv
logic/exu_regfile.sv
logic/exu_decode.sv
logic/exu_alu.sv
logic/exu_execute.sv
logic/exu_hazard_ctrl.sv
logic/exu_top.sv
test/exu_tb.sv

// File: include/exu_config.svh
// =========================================================================
// Execute subsystem configuration
// Data width and register file geometry
// =========================================================================

`ifndef EXU_CONFIG_SVH
`define EXU_CONFIG_SVH

// Integer data width
`define EXU_XLEN 32

// Architectural registers, x0 included
`define EXU_NREGS 32

// Register index width
`define EXU_RADDR_W 5

`endif

// File: logic/exu_alu.sv
// =========================================================================
// Integer ALU with one shared adder and one shared shifter
// =========================================================================

`timescale 1ns/100ps
`default_nettype none

`include "exu_config.svh"

module exu_alu
    import exu_pkg::*;
(
    input  logic [`EXU_XLEN-1:0] op1,
    input  logic [`EXU_XLEN-1:0] op2,
    input  alu_op_e              alu_op,
    output logic [`EXU_XLEN-1:0] result
);

localparam int SHAMT_W = $clog2(`EXU_XLEN);

logic                        sub;
logic [`EXU_XLEN:0]          sum;
logic                        lt_unsigned;
logic                        lt_signed;
logic                        shl;
logic [`EXU_XLEN-1:0]        shift_in;
logic signed [`EXU_XLEN:0]   shift_ext;
logic [`EXU_XLEN-1:0]        shift_out;
logic [`EXU_XLEN-1:0]        shift_rev;

// =========================================================================
// Adder, also used for compares

assign sub = (alu_op == ALU_SUB) || (alu_op == ALU_SLT) || (alu_op == ALU_SLTU);
assign sum = {1'b0, op1} + {1'b0, op2 ^ {`EXU_XLEN{sub}}} + {{`EXU_XLEN{1'b0}}, sub};

// No carry out of op1 - op2 means op1 < op2
assign lt_unsigned = ~sum[`EXU_XLEN];
assign lt_signed   = (op1[`EXU_XLEN-1] != op2[`EXU_XLEN-1]) ? op1[`EXU_XLEN-1]
                                                            : sum[`EXU_XLEN-1];

// =========================================================================
// Shifter, left shifts run through bit reversal

assign shl = (alu_op == ALU_SLL);

always_comb begin
    for (int i = 0; i < `EXU_XLEN; i++) begin
        shift_in[i]  = shl ? op1[`EXU_XLEN-1-i] : op1[i];
        shift_rev[i] = shift_out[`EXU_XLEN-1-i];
    end
end

assign shift_ext = {(alu_op == ALU_SRA) & op1[`EXU_XLEN-1], shift_in};
assign shift_out = `EXU_XLEN'(shift_ext >>> op2[SHAMT_W-1:0]);

always_comb begin
    case (alu_op)
        ALU_ADD, ALU_SUB: result = sum[`EXU_XLEN-1:0];
        ALU_AND:          result = op1 & op2;
        ALU_OR:           result = op1 | op2;
        ALU_XOR:          result = op1 ^ op2;
        ALU_SLT:          result = {{(`EXU_XLEN-1){1'b0}}, lt_signed};
        ALU_SLTU:         result = {{(`EXU_XLEN-1){1'b0}}, lt_unsigned};
        ALU_SLL:          result = shift_rev;
        ALU_SRL, ALU_SRA: result = shift_out;
        default:          result = op2;
    endcase
end

endmodule

`default_nettype wire

// File: logic/exu_decode.sv
// =========================================================================
// Decode pipestage: instruction decode, operand read, ALU control
// =========================================================================

`timescale 1ns/100ps
`default_nettype none

`include "exu_config.svh"

module exu_decode
    import exu_pkg::*;
(
    input  logic                    clk,
    input  logic                    rstz,
    input  logic                    flush,
    input  logic                    stall,
    // Instruction in
    input  logic                    instr_vld,
    output logic                    instr_rdy,
    input  logic [31:0]             instr,
    input  logic [`EXU_XLEN-1:0]    instr_pc,
    // Operand read and hazard sources
    exu_regfile_if.reader           rd_port,
    output logic [`EXU_RADDR_W-1:0] rs1,
    output logic [`EXU_RADDR_W-1:0] rs2,
    output logic                    uses_rs2,
    // ID/EX
    output pipe_idex_t              decode,
    output logic                    idex_vld,
    input  logic                    idex_rdy
);

logic [6:0]              opcode;
logic [2:0]              funct3;
logic [6:0]              funct7;
logic [`EXU_RADDR_W-1:0] rd;
logic                    is_op;
logic                    is_op_imm;
logic                    is_lui;
logic                    f7_zero;
logic                    f7_alt;
logic                    legal;
alu_op_e                 alu_op;
logic [`EXU_XLEN-1:0]    imm_i;
logic [`EXU_XLEN-1:0]    imm_u;
pipe_idex_t              idex_next;

// =========================================================================
// Field extraction

assign opcode = instr[6:0];
assign rd     = instr[11:7];
assign funct3 = instr[14:12];
assign funct7 = instr[31:25];

assign is_op     = (opcode == OPC_OP);
assign is_op_imm = (opcode == OPC_OP_IMM);
assign is_lui    = (opcode == OPC_LUI);

assign f7_zero = (funct7 == 7'b0000000);
assign f7_alt  = (funct7 == 7'b0100000);

assign imm_i = {{(`EXU_XLEN-12){instr[31]}}, instr[31:20]};
assign imm_u = {instr[31:12], 12'b0};

always_comb begin
    case (funct3)
        3'b000:  alu_op = (is_op && funct7[5]) ? ALU_SUB : ALU_ADD;
        3'b001:  alu_op = ALU_SLL;
        3'b010:  alu_op = ALU_SLT;
        3'b011:  alu_op = ALU_SLTU;
        3'b100:  alu_op = ALU_XOR;
        3'b101:  alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
        3'b110:  alu_op = ALU_OR;
        default: alu_op = ALU_AND;
    endcase
    if (is_lui) begin
        alu_op = ALU_PASS;
    end
end

// Only SUB and SRA/SRAI may use the alternate funct7
always_comb begin
    legal = 1'b0;
    if (is_lui) begin
        legal = 1'b1;
    end
    else if (is_op) begin
        legal = f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101));
    end
    else if (is_op_imm) begin
        case (funct3)
            3'b001:  legal = f7_zero;
            3'b101:  legal = f7_zero || f7_alt;
            default: legal = 1'b1;
        endcase
    end
end

// =========================================================================
// Operand read

// LUI has no source register, its rs1 field is immediate
assign rs1      = is_lui ? '0 : instr[19:15];
assign rs2      = instr[24:20];
assign uses_rs2 = is_op;

assign rd_port.rs1_addr = rs1;
assign rd_port.rs2_addr = rs2;

always_comb begin
    idex_next.pc         = instr_pc;
    idex_next.op1        = is_lui ? '0 : rd_port.rs1_data;
    idex_next.op2        = is_op ? rd_port.rs2_data : (is_lui ? imm_u : imm_i);
    idex_next.alu_op     = alu_op;
    idex_next.rd         = rd;
    idex_next.rd_write   = legal && (rd != '0);
    idex_next.is_illegal = ~legal;
end

// =========================================================================
// ID/EX pipe register

assign instr_rdy = (~idex_vld | idex_rdy) & ~stall;

always_ff @(posedge clk or negedge rstz) begin
    if (~rstz) begin
        idex_vld <= 1'b0;
    end
    else if (flush) begin
        idex_vld <= 1'b0;
    end
    else if (instr_vld && instr_rdy) begin
        idex_vld <= 1'b1;
    end
    else if (idex_vld && idex_rdy) begin
        idex_vld <= 1'b0;
    end
end

always_ff @(posedge clk) begin
    if (instr_vld && instr_rdy) begin
        decode <= idex_next;
    end
end

endmodule

`default_nettype wire

// File: logic/exu_execute.sv
// =========================================================================
// Execute pipestage: ALU result register and retire strobe
// =========================================================================

`timescale 1ns/100ps
`default_nettype none

`include "exu_config.svh"

module exu_execute
    import exu_pkg::*;
(
    input  logic       clk,
    input  logic       rstz,
    input  logic       flush,
    // ID/EX
    input  pipe_idex_t decode,
    input  logic       idex_vld,
    output logic       idex_rdy,
    // EX/WB
    output pipe_exwb_t execute,
    output logic       result_vld,
    input  logic       result_rdy,
    output logic       retire
);

logic [`EXU_XLEN-1:0] alu_result;

exu_alu u_alu (
    .op1    (decode.op1   ),
    .op2    (decode.op2   ),
    .alu_op (decode.alu_op),
    .result (alu_result   )
);

assign idex_rdy = ~result_vld | result_rdy;

always_ff @(posedge clk or negedge rstz) begin
    if (~rstz) begin
        result_vld <= 1'b0;
    end
    else if (flush) begin
        result_vld <= 1'b0;
    end
    else if (idex_vld && idex_rdy) begin
        result_vld <= 1'b1;
    end
    else if (result_vld && result_rdy) begin
        result_vld <= 1'b0;
    end
end

always_ff @(posedge clk) begin
    if (idex_vld && idex_rdy) begin
        execute.pc         <= decode.pc;
        execute.result     <= alu_result;
        execute.rd         <= decode.rd;
        execute.rd_write   <= decode.rd_write;
        execute.is_illegal <= decode.is_illegal;
    end
end

// A flushed result never reaches the register file
assign retire = result_vld & result_rdy & execute.rd_write & ~flush;

a_hold_stable: assert property (
    @(posedge clk) disable iff (!rstz)
    result_vld && !result_rdy && !flush |=> $stable(execute)
);

endmodule

`default_nettype wire

// File: logic/exu_hazard_ctrl.sv
// =========================================================================
// Hazard control for RAW stalls on pending destinations and flush fan-out
// =========================================================================

`timescale 1ns/100ps
`default_nettype none

`include "exu_config.svh"

module exu_hazard_ctrl (
    input  logic                    flush_in,
    // Sources of the instruction at decode
    input  logic [`EXU_RADDR_W-1:0] rs1,
    input  logic [`EXU_RADDR_W-1:0] rs2,
    input  logic                    uses_rs2,
    // ID/EX destination
    input  logic                    idex_vld,
    input  logic [`EXU_RADDR_W-1:0] idex_rd,
    input  logic                    idex_write,
    // EX/WB destination
    input  logic                    ex_vld,
    input  logic [`EXU_RADDR_W-1:0] ex_rd,
    input  logic                    ex_write,
    output logic                    stall,
    output logic                    flush
);

logic rs1_hit;
logic rs2_hit;

// Source is still waiting on an older write held in one stage
function automatic logic pending(
    input logic [`EXU_RADDR_W-1:0] src,
    input logic                    vld,
    input logic [`EXU_RADDR_W-1:0] dst,
    input logic                    write
);
    return (src != '0) && vld && write && (dst == src);
endfunction

assign rs1_hit = pending(rs1, idex_vld, idex_rd, idex_write)
              || pending(rs1, ex_vld, ex_rd, ex_write);
assign rs2_hit = uses_rs2 && (pending(rs2, idex_vld, idex_rd, idex_write)
                           || pending(rs2, ex_vld, ex_rd, ex_write));

// Flush also blocks new instructions for its cycle
assign stall = flush_in | rs1_hit | rs2_hit;
assign flush = flush_in;

endmodule

`default_nettype wire

// File: logic/exu_pkg.sv
// =========================================================================
// Execute subsystem types
// Opcodes, ALU operations and pipe register layouts
// =========================================================================

`default_nettype none

`include "exu_config.svh"

package exu_pkg;

// RV32I major opcodes handled here
typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111
} opcode_e;

typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_PASS
} alu_op_e;

// Decode to execute
typedef struct packed {
    logic [`EXU_XLEN-1:0]    pc;
    logic [`EXU_XLEN-1:0]    op1;
    logic [`EXU_XLEN-1:0]    op2;
    alu_op_e                 alu_op;
    logic [`EXU_RADDR_W-1:0] rd;
    logic                    rd_write;
    logic                    is_illegal;
} pipe_idex_t;

// Execute to writeback
typedef struct packed {
    logic [`EXU_XLEN-1:0]    pc;
    logic [`EXU_XLEN-1:0]    result;
    logic [`EXU_RADDR_W-1:0] rd;
    logic                    rd_write;
    logic                    is_illegal;
} pipe_exwb_t;

endpackage

`default_nettype wire

// File: logic/exu_regfile.sv
// =========================================================================
// Integer register file, two asynchronous reads and one retire write
// =========================================================================

`timescale 1ns/100ps
`default_nettype none

`include "exu_config.svh"

module exu_regfile
    import exu_pkg::*;
(
    input  logic                 clk,
    input  logic                 rstz,
    exu_regfile_if.server        rd_port,
    input  logic                 retire,
    input  pipe_exwb_t           wb
);

logic [`EXU_XLEN-1:0] regs [`EXU_NREGS];

// x0 always reads as zero
assign rd_port.rs1_data = (rd_port.rs1_addr == '0) ? '0 : regs[rd_port.rs1_addr];
assign rd_port.rs2_data = (rd_port.rs2_addr == '0) ? '0 : regs[rd_port.rs2_addr];

always_ff @(posedge clk or negedge rstz) begin
    if (~rstz) begin
        for (int i = 0; i < `EXU_NREGS; i++) begin
            regs[i] <= '0;
        end
    end
    else if (retire && wb.rd_write && (wb.rd != '0)) begin
        regs[wb.rd] <= wb.result;
    end
end

// Decode never marks x0 as a destination
a_no_x0_write: assert property (
    @(posedge clk) disable iff (!rstz)
    retire && wb.rd_write |-> wb.rd != '0
);

endmodule

`default_nettype wire

// File: logic/exu_regfile_if.sv
// =========================================================================
// Register file read path with two source ports
// =========================================================================

`timescale 1ns/100ps
`default_nettype none

`include "exu_config.svh"

interface exu_regfile_if;

logic [`EXU_RADDR_W-1:0] rs1_addr;
logic [`EXU_RADDR_W-1:0] rs2_addr;
logic [`EXU_XLEN-1:0]    rs1_data;
logic [`EXU_XLEN-1:0]    rs2_data;

modport reader (output rs1_addr, rs2_addr, input rs1_data, rs2_data);
modport server (input rs1_addr, rs2_addr, output rs1_data, rs2_data);

endinterface

`default_nettype wire

// File: logic/exu_top.sv
// =========================================================================
// Execute subsystem top: decode, execute, register file and hazard control
// =========================================================================

`timescale 1ns/100ps
`default_nettype none

`include "exu_config.svh"

module exu_top
    import exu_pkg::*;
(
    input  logic                    clk,
    input  logic                    rstz,
    // Instruction in
    input  logic                    instr_vld,
    output logic                    instr_rdy,
    input  logic [31:0]             instr,
    input  logic [`EXU_XLEN-1:0]    instr_pc,
    input  logic                    flush,
    // Result out
    output logic                    result_vld,
    input  logic                    result_rdy,
    output logic [`EXU_XLEN-1:0]    result_pc,
    output logic [`EXU_XLEN-1:0]    result_data,
    output logic [`EXU_RADDR_W-1:0] result_rd,
    output logic                    result_illegal
);

pipe_idex_t              idex_data;
pipe_exwb_t              exwb_data;
logic                    idex_vld;
logic                    idex_rdy;
logic                    retire;
logic                    stall;
logic                    pipe_flush;
logic [`EXU_RADDR_W-1:0] rs1;
logic [`EXU_RADDR_W-1:0] rs2;
logic                    uses_rs2;

exu_regfile_if rf_if ();

exu_regfile u_regfile (
    .clk     (clk      ),
    .rstz    (rstz     ),
    .rd_port (rf_if    ),
    .retire  (retire   ),
    .wb      (exwb_data)
);

exu_decode u_decode (
    .clk       (clk       ),
    .rstz      (rstz      ),
    .flush     (pipe_flush),
    .stall     (stall     ),
    .instr_vld (instr_vld ),
    .instr_rdy (instr_rdy ),
    .instr     (instr     ),
    .instr_pc  (instr_pc  ),
    .rd_port   (rf_if     ),
    .rs1       (rs1       ),
    .rs2       (rs2       ),
    .uses_rs2  (uses_rs2  ),
    .decode    (idex_data ),
    .idex_vld  (idex_vld  ),
    .idex_rdy  (idex_rdy  )
);

exu_execute u_execute (
    .clk        (clk       ),
    .rstz       (rstz      ),
    .flush      (pipe_flush),
    .decode     (idex_data ),
    .idex_vld   (idex_vld  ),
    .idex_rdy   (idex_rdy  ),
    .execute    (exwb_data ),
    .result_vld (result_vld),
    .result_rdy (result_rdy),
    .retire     (retire    )
);

exu_hazard_ctrl u_hazard_ctrl (
    .flush_in   (flush             ),
    .rs1        (rs1               ),
    .rs2        (rs2               ),
    .uses_rs2   (uses_rs2          ),
    .idex_vld   (idex_vld          ),
    .idex_rd    (idex_data.rd      ),
    .idex_write (idex_data.rd_write),
    .ex_vld     (result_vld        ),
    .ex_rd      (exwb_data.rd      ),
    .ex_write   (exwb_data.rd_write),
    .stall      (stall             ),
    .flush      (pipe_flush        )
);

assign result_pc      = exwb_data.pc;
assign result_data    = exwb_data.result;
assign result_rd      = exwb_data.rd;
assign result_illegal = exwb_data.is_illegal;

endmodule

`default_nettype wire

// File: test/exu_patterns.txt
// pc       instr    rd data     illegal flush
// data is the expected result_data, ignored when illegal is 1
00000100 800000B7 01 80000000 0 0
00000104 FFB00113 02 FFFFFFFB 0 0
00000108 00700193 03 00000007 0 0
0000010C 40218233 04 0000000C 0 0
00000110 003122B3 05 00000001 0 0
00000114 00313333 06 00000000 0 0
00000118 4030D3B3 07 FF000000 0 0
0000011C 00419493 09 00000070 0 0
00000120 0F014513 0A FFFFFF0B 0 0
00000124 009565B3 0B FFFFFF7B 0 0
00000128 FF05F613 0C FFFFFF70 0 0
0000012C 000001FF 03 00000000 1 0
00000130 05500193 03 00000055 0 1
00000134 000186B3 0D 00000007 0 0
00000138 00120013 00 0000000D 0 0
0000013C 40020733 0E 0000000C 0 0

// File: test/exu_tb.sv
// ==========================================================================
// Execute subsystem testbench, driven from a pattern file
// ==========================================================================

`timescale 1ns/100ps
`default_nettype none

`include "exu_config.svh"

module exu_tb;

localparam int TIMEOUT = 200;
localparam int MAX_PAT = 64;

logic                    clk = 1'b0;
logic                    rstz;
logic                    instr_vld;
logic                    instr_rdy;
logic [31:0]             instr;
logic [`EXU_XLEN-1:0]    instr_pc;
logic                    flush;
logic                    result_vld;
logic                    result_rdy;
logic [`EXU_XLEN-1:0]    result_pc;
logic [`EXU_XLEN-1:0]    result_data;
logic [`EXU_RADDR_W-1:0] result_rd;
logic                    result_illegal;

// Pattern table
logic [31:0] pat_pc      [MAX_PAT];
logic [31:0] pat_instr   [MAX_PAT];
logic [31:0] pat_rd      [MAX_PAT];
logic [31:0] pat_data    [MAX_PAT];
logic        pat_illegal [MAX_PAT];
logic        pat_flush   [MAX_PAT];
int          n_pat = 0;

int   errors = 0;
int   checked = 0;
int   flushes_done = 0;
int   extra = 0;
logic timed_out = 1'b0;

always #2 clk = ~clk;

exu_top exu_top_i (
    .clk            (clk           ),
    .rstz           (rstz          ),
    .instr_vld      (instr_vld     ),
    .instr_rdy      (instr_rdy     ),
    .instr          (instr         ),
    .instr_pc       (instr_pc      ),
    .flush          (flush         ),
    .result_vld     (result_vld    ),
    .result_rdy     (result_rdy    ),
    .result_pc      (result_pc     ),
    .result_data    (result_data   ),
    .result_rd      (result_rd     ),
    .result_illegal (result_illegal)
);

// ==========================================================================
// Helpers

task automatic load_patterns();
    int          fd;
    int          rc;
    string       line;
    logic [31:0] f [6];
    fd = $fopen("test/exu_patterns.txt", "r");
    if (fd == 0) begin
        errors = errors + 1;
        $display("cannot open the pattern file test/exu_patterns.txt");
    end
    else begin
        while (!$feof(fd) && n_pat < MAX_PAT) begin
            rc = $fgets(line, fd);
            // Comment and blank lines give fewer than six fields
            if (rc > 0 && $sscanf(line, "%h %h %h %h %h %h",
                                  f[0], f[1], f[2], f[3], f[4], f[5]) == 6) begin
                pat_pc[n_pat]      = f[0];
                pat_instr[n_pat]   = f[1];
                pat_rd[n_pat]      = f[2];
                pat_data[n_pat]    = f[3];
                pat_illegal[n_pat] = f[4][0];
                pat_flush[n_pat]   = f[5][0];
                n_pat = n_pat + 1;
            end
        end
        $fclose(fd);
    end
endtask

task automatic compare_field(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
        errors = errors + 1;
        $display("[ERROR] %0t %s expected %h actual %h", $time, name, expected, actual);
    end
endtask

// Offers each instruction; a flush-marked one is followed by a pause
task automatic drive_instructions();
    int waited;
    int target;
    for (int i = 0; i < n_pat && !timed_out; i++) begin
        #1;
        instr_vld = 1'b1;
        instr     = pat_instr[i];
        instr_pc  = pat_pc[i];
        waited    = 0;
        @(posedge clk);
        while (!instr_rdy && !timed_out) begin
            waited = waited + 1;
            if (waited >= TIMEOUT) begin
                timed_out = 1'b1;
                $display("instr_rdy stayed low while offering pc %h", pat_pc[i]);
            end
            @(posedge clk);
        end
        if (pat_flush[i]) begin
            target = flushes_done + 1;
            waited = 0;
            #1;
            instr_vld = 1'b0;
            while (flushes_done < target && !timed_out) begin
                @(posedge clk);
                waited = waited + 1;
                if (waited >= TIMEOUT) begin
                    timed_out = 1'b1;
                    $display("flush of pc %h never completed", pat_pc[i]);
                end
            end
        end
    end
    #1;
    instr_vld = 1'b0;
endtask

// Takes results in order with random back-pressure, flushes marked ones
task automatic monitor_results();
    int   waited;
    logic got;
    for (int j = 0; j < n_pat && !timed_out; j++) begin
        waited = 0;
        got    = 1'b0;
        while (!got && !timed_out) begin
            #1;
            result_rdy = pat_flush[j] ? 1'b0 : (($urandom % 100) >= 30);
            @(posedge clk);
            if (result_vld && (result_rdy || pat_flush[j])) begin
                got = 1'b1;
            end
            else begin
                waited = waited + 1;
                if (waited >= TIMEOUT) begin
                    timed_out = 1'b1;
                    $display("no result arrived for pc %h", pat_pc[j]);
                end
            end
        end
        if (got) begin
            compare_field("result_pc", pat_pc[j], result_pc);
            compare_field("result_rd", pat_rd[j], 32'(result_rd));
            compare_field("result_illegal", 32'(pat_illegal[j]), 32'(result_illegal));
            if (!pat_illegal[j]) begin
                compare_field("result_data", pat_data[j], result_data);
            end
            checked = checked + 1;
            if (pat_flush[j]) begin
                #1;
                flush = 1'b1;
                @(posedge clk);
                #1;
                flush = 1'b0;
                if (result_vld) begin
                    errors = errors + 1;
                    $display("result_vld still high after flushing pc %h", pat_pc[j]);
                end
                flushes_done = flushes_done + 1;
                @(posedge clk);
            end
        end
    end
endtask

// ==========================================================================
// Main sequence

initial begin
    $timeformat(-9, 1, " ns", 0);
    void'($urandom(32'h28f7a3cd));
    rstz       = 1'b0;
    instr_vld  = 1'b0;
    instr      = '0;
    instr_pc   = '0;
    flush      = 1'b0;
    result_rdy = 1'b0;
    load_patterns();
    repeat (8) @(posedge clk);
    #1;
    rstz = 1'b1;
    @(posedge clk);
    if (!instr_rdy || result_vld) begin
        errors = errors + 1;
        $display("pipe not idle and ready after reset");
    end
    fork
        drive_instructions();
        monitor_results();
    join
    // Nothing may follow the last expected result
    if (!timed_out) begin
        #1;
        result_rdy = 1'b1;
        repeat (8) begin
            @(posedge clk);
            if (result_vld) begin
                extra = extra + 1;
            end
        end
        if (extra != 0) begin
            errors = errors + 1;
            $display("unexpected results after the last pattern");
        end
    end
    if (timed_out) begin
        errors = errors + 1;
    end
    $display("results checked: %0d of %0d, errors: %0d", checked, n_pat, errors);
    if (errors == 0) begin
        $display("test passed");
    end
    else begin
        $display("test failed");
    end
    $finish;
end

endmodule

`default_nettype wire
